/* sim.f */
+incdir+.
ahb_bus_pkg.sv
ahb_master_pkg.sv
ahb_cmd_check.sv
ahb_burst_addr.sv
ahb_master_ctrl.sv
ahb_master.sv
tb_ahb_slave.sv
tb_ahb_master.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module tb_ahb_master -o sim_tb &&
    ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" &&
    echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_ahb_master.sv */
// Testbench for the AHB master. Random burst commands run through the DUT into a
// behavioral slave; addresses, data and completion are checked against a model.
`timescale 1ns/1ps
`include "ahb_defs.svh"

module tb_ahb_master;

    localparam int CYCLE_LIMIT = 200 * (16 * 4 + 10);

    logic                 ahb_clk_in = 1'b0;
    logic                 ahb_rstn_in;
    logic                 cmd_valid, cmd_ready, cmd_write;
    ahb_bus_pkg::haddr_t  cmd_addr, haddr;
    ahb_bus_pkg::hburst_e cmd_burst, hburst;
    ahb_bus_pkg::hsize_t  cmd_size, hsize;
    ahb_bus_pkg::hdata_t  wdata, rdata, hwdata, hrdata;
    logic                 wdata_ack, rdata_valid, xfer_done, xfer_error;
    ahb_bus_pkg::htrans_e htrans;
    logic                 hwrite, hready, hresp;

    logic [15:0]          lfsr = 16'd68;
    ahb_bus_pkg::hdata_t  model_mem [0:4095];
    ahb_bus_pkg::hdata_t  wq[$];
    ahb_bus_pkg::haddr_t  got_addr[$];
    ahb_bus_pkg::hdata_t  got_rd[$];
    int                   cyc = 0;
    int                   acc_cyc, first_cyc, done_cyc, ack_cnt;
    logic                 done_seen, done_err, any_trans;

    ahb_master DUT (.*);

    tb_ahb_slave u_slave (
        .ahb_clk_in (ahb_clk_in), .ahb_rstn_in (ahb_rstn_in), .haddr (haddr),
        .htrans (htrans), .hsize (hsize), .hwrite (hwrite), .hwdata (hwdata),
        .hrdata (hrdata), .hready (hready), .hresp (hresp)
    );

    always #20 ahb_clk_in = ~ahb_clk_in;

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            lfsr = {lfsr[14:0], v[0]};
        end
        return v;
    endfunction

    function automatic int beat_count(ahb_bus_pkg::hburst_e b);
        case (b)
            ahb_bus_pkg::WRAP4, ahb_bus_pkg::INCR4:   return 4;
            ahb_bus_pkg::WRAP8, ahb_bus_pkg::INCR8:   return 8;
            ahb_bus_pkg::WRAP16, ahb_bus_pkg::INCR16: return 16;
            default:                                  return 1;
        endcase
    endfunction

    function automatic logic is_wrap(ahb_bus_pkg::hburst_e b);
        return b == ahb_bus_pkg::WRAP4 || b == ahb_bus_pkg::WRAP8 || b == ahb_bus_pkg::WRAP16;
    endfunction

    function automatic logic legal_cmd(ahb_bus_pkg::haddr_t a, ahb_bus_pkg::hburst_e b,
                                       ahb_bus_pkg::hsize_t s);
        ahb_bus_pkg::haddr_t span, first, last;
        span  = ahb_bus_pkg::haddr_t'(beat_count(b) << s);
        first = is_wrap(b) ? (a & ~(span - 1)) : a;
        last  = first + span - 1;
        return b != ahb_bus_pkg::INCR && s <= 3'd2
            && (a & ((ahb_bus_pkg::haddr_t'(1) << s) - 1)) == '0
            && first[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS]
               == last[`AHB_ADDR_WIDTH-1:`AHB_BOUNDARY_BITS];
    endfunction

    // Wrapping bursts fold the offset back into the span-aligned block.
    function automatic ahb_bus_pkg::haddr_t beat_address(ahb_bus_pkg::haddr_t a,
            ahb_bus_pkg::hburst_e b, ahb_bus_pkg::hsize_t s, int i);
        ahb_bus_pkg::haddr_t span, step, base;
        span = ahb_bus_pkg::haddr_t'(beat_count(b) << s);
        step = ahb_bus_pkg::haddr_t'(i << s);
        base = a & ~(span - 1);
        return is_wrap(b) ? base + ((a - base + step) % span) : a + step;
    endfunction

    function automatic ahb_bus_pkg::haddr_t legal_addr(ahb_bus_pkg::hburst_e b,
                                                       ahb_bus_pkg::hsize_t s);
        ahb_bus_pkg::haddr_t a;
        a = ahb_bus_pkg::haddr_t'(rand_bits(12)) & ~((ahb_bus_pkg::haddr_t'(1) << s) - 1);
        if (!legal_cmd(a, b, s)) begin
            a = a & ~(ahb_bus_pkg::haddr_t'(beat_count(b) << s) - 1);
        end
        return a;
    endfunction

    function automatic void model_write(ahb_bus_pkg::haddr_t a, ahb_bus_pkg::hsize_t s,
                                        ahb_bus_pkg::hdata_t d);
        int lo;
        lo = int'(a[1:0]);
        for (int b = lo; b < lo + (1 << s); b++) begin
            model_mem[a[13:2]][8*b +: 8] = d[8*b +: 8];
        end
    endfunction

    task automatic check_value(string test, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // ******************************
    // Bus monitor and write data
    // ******************************
    always @(posedge ahb_clk_in) begin
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            cyc <= cyc + 1;
            if (cmd_valid && cmd_ready) acc_cyc <= cyc;
            if (htrans != ahb_bus_pkg::IDLE) any_trans <= 1'b1;
            if (htrans == ahb_bus_pkg::NONSEQ && first_cyc < 0) first_cyc <= cyc;
            if ((htrans == ahb_bus_pkg::NONSEQ || htrans == ahb_bus_pkg::SEQ) && hready) begin
                got_addr.push_back(haddr);
                check_value("hburst", 32'(cmd_burst), 32'(hburst));
            end
            if (wdata_ack) begin
                ack_cnt <= ack_cnt + 1;
                if (ack_cnt + 1 < wq.size()) wdata <= wq[ack_cnt + 1];  // Next beat.
            end
            if (rdata_valid) got_rd.push_back(rdata);
            if (xfer_done) begin
                done_seen <= 1'b1;
                done_err  <= xfer_error;
                done_cyc  <= cyc;
            end
        end
    end

    task automatic run_cmd(string test, ahb_bus_pkg::haddr_t addr, ahb_bus_pkg::hburst_e burst,
                           ahb_bus_pkg::hsize_t size, logic write);
        int   n;
        logic legal;
        ahb_bus_pkg::haddr_t a;
        n     = beat_count(burst);
        legal = legal_cmd(addr, burst, size);
        wq.delete();
        got_addr.delete();
        got_rd.delete();
        for (int i = 0; i < n; i++) wq.push_back(rand_bits(32));
        cmd_valid <= 1'b1;
        cmd_addr  <= addr;
        cmd_burst <= burst;
        cmd_size  <= size;
        cmd_write <= write;
        wdata     <= wq[0];
        done_seen <= 1'b0;
        any_trans <= 1'b0;
        first_cyc <= -1;
        ack_cnt   <= 0;
        do @(posedge ahb_clk_in); while (!cmd_ready);
        cmd_valid <= 1'b0;
        while (!done_seen) @(posedge ahb_clk_in);
        check_value({test, " cmd_ready"}, 32'd1, 32'(cmd_ready));
        check_value({test, " xfer_error"}, 32'(!legal || addr[12] || addr[13]), 32'(done_err));
        if (!legal) begin
            // Pulse is driven two edges after acceptance and seen on the edge after.
            check_value({test, " latency"}, 32'd2, 32'(done_cyc - acc_cyc - 1));
            check_value({test, " htrans busy"}, 32'd0, 32'(any_trans));
        end else if (addr[13]) begin
            assert (done_cyc - first_cyc <= `AHB_WAIT_TIMEOUT + 3) else begin
                $display("CHECK FAILED %s timeout: expected at most %0d, actual %0d",
                         test, `AHB_WAIT_TIMEOUT + 3, done_cyc - first_cyc);
                $display("TEST FAILED");
                $fatal(1);
            end
        end else if (addr[12]) begin
            // The first beat errors, so no later address phase may be taken.
            check_value({test, " beats"}, 32'd1, 32'(got_addr.size()));
        end else begin
            check_value({test, " beats"}, 32'(n), 32'(got_addr.size()));
            check_value({test, " acks"}, write ? 32'(n) : 32'd0, 32'(ack_cnt));
            check_value({test, " reads"}, write ? 32'd0 : 32'(n), 32'(got_rd.size()));
            for (int i = 0; i < n; i++) begin
                a = beat_address(addr, burst, size, i);
                check_value({test, " haddr"}, a, got_addr[i]);
                if (write) model_write(a, size, wq[i]);
                else check_value({test, " rdata"}, model_mem[a[13:2]], got_rd[i]);
            end
        end
        while (!hready) @(posedge ahb_clk_in);  // Let a stalled slave recover.
    endtask

    initial begin
        ahb_bus_pkg::haddr_t  a;
        ahb_bus_pkg::hburst_e b;
        ahb_bus_pkg::hsize_t  s;
        logic [31:0]          r;
        ahb_rstn_in = 1'b0;
        cmd_valid   = 1'b0;
        cmd_addr    = '0;
        cmd_burst   = ahb_bus_pkg::SINGLE;
        cmd_size    = '0;
        cmd_write   = 1'b0;
        wdata       = '0;
        for (int i = 0; i < 4096; i++) model_mem[i] = {4'hA, 12'(i), 4'h5, 12'(i)};
        repeat (3) @(posedge ahb_clk_in);
        ahb_rstn_in <= 1'b1;
        @(posedge ahb_clk_in);

        // Every fixed-length burst and size is written and then read back.
        for (int k = 0; k < 8; k++) begin
            for (int z = 0; z < 3; z++) begin
                b = ahb_bus_pkg::hburst_e'(k);
                s = ahb_bus_pkg::hsize_t'(z);
                if (b != ahb_bus_pkg::INCR) begin
                    a = legal_addr(b, s);
                    run_cmd(is_wrap(b) ? "wrap write" : "incr write", a, b, s, 1'b1);
                    run_cmd(is_wrap(b) ? "wrap read" : "incr read", a, b, s, 1'b0);
                end
            end
        end
        for (int k = 0; k < 40; k++) begin
            r = rand_bits(6);
            b = (r[2:0] == 3'd1) ? ahb_bus_pkg::WRAP16 : ahb_bus_pkg::hburst_e'(r[2:0]);
            s = (r[4:3] == 2'd3) ? 3'd2 : {1'b0, r[4:3]};
            run_cmd("random", legal_addr(b, s), b, s, r[5]);
        end

        run_cmd("misaligned", 32'h102, ahb_bus_pkg::INCR4, 3'd2, 1'b1);
        run_cmd("oversized", 32'h100, ahb_bus_pkg::SINGLE, 3'd3, 1'b1);
        run_cmd("incr type", 32'h100, ahb_bus_pkg::INCR, 3'd2, 1'b0);
        run_cmd("boundary", 32'h3F0, ahb_bus_pkg::INCR16, 3'd2, 1'b1);
        run_cmd("error write", 32'h1000 | legal_addr(ahb_bus_pkg::INCR4, 3'd2),
                ahb_bus_pkg::INCR4, 3'd2, 1'b1);
        run_cmd("error read", 32'h1010, ahb_bus_pkg::SINGLE, 3'd2, 1'b0);
        run_cmd("stall write", 32'h2000, ahb_bus_pkg::INCR4, 3'd2, 1'b1);
        run_cmd("stall read", 32'h2040, ahb_bus_pkg::SINGLE, 3'd2, 1'b0);

        $display("TEST OK");
        $finish;
    end

endmodule

/* tb_ahb_slave.sv */
// Behavioral AHB slave for the master testbench. Word memory with random wait states.
// Address bit 12 answers ERROR and address bit 13 stalls the data phase.
`timescale 1ns/1ps

module tb_ahb_slave (
    input  logic                 ahb_clk_in,
    input  logic                 ahb_rstn_in,
    input  ahb_bus_pkg::haddr_t  haddr,
    input  ahb_bus_pkg::htrans_e htrans,
    input  ahb_bus_pkg::hsize_t  hsize,
    input  logic                 hwrite,
    input  ahb_bus_pkg::hdata_t  hwdata,
    output ahb_bus_pkg::hdata_t  hrdata,
    output logic                 hready,
    output logic                 hresp
);

    localparam int STALL_CYCLES = 16;  // Well past the master's wait timeout.

    ahb_bus_pkg::hdata_t mem [0:4095];
    logic [15:0]         lfsr = 16'd68;
    logic                dp_active;
    logic                dp_write;
    logic                err_second;  // Second cycle of the ERROR response.
    ahb_bus_pkg::haddr_t dp_addr;
    ahb_bus_pkg::hsize_t dp_size;
    int                  wait_left;
    int                  lane_lo;
    ahb_bus_pkg::hdata_t word;
    logic                in_err;
    logic                in_stall;

    function automatic logic [1:0] draw_waits();
        logic [1:0] v;
        v = '0;
        for (int i = 0; i < 2; i++) begin
            v    = {v[0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            lfsr = {lfsr[14:0], v[0]};
        end
        return v;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {4'hA, 12'(i), 4'h5, 12'(i)};
        end
    end

    assign in_err   = dp_active && dp_addr[12];
    assign in_stall = dp_active && dp_addr[13];
    assign hrdata   = mem[dp_addr[13:2]];

    always_comb begin
        hready = 1'b1;
        hresp  = 1'b0;
        if (dp_active && wait_left != 0) begin
            hready = 1'b0;
        end else if (in_err) begin
            hresp  = 1'b1;  // Two-cycle ERROR response.
            hready = err_second;
        end
    end

    always @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            dp_active  <= 1'b0;
            dp_write   <= 1'b0;
            dp_addr    <= '0;
            dp_size    <= '0;
            wait_left  <= 0;
            err_second <= 1'b0;
        end else if (hready) begin
            dp_active  <= (htrans == ahb_bus_pkg::NONSEQ) || (htrans == ahb_bus_pkg::SEQ);
            dp_addr    <= haddr;
            dp_write   <= hwrite;
            dp_size    <= hsize;
            err_second <= 1'b0;
            wait_left  <= haddr[13] ? STALL_CYCLES : int'(draw_waits());
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
        end else begin
            err_second <= 1'b1;
        end
    end

    // Only completed, error-free beats reach the memory.
    always @(posedge ahb_clk_in) begin
        if (hready && dp_active && dp_write && !in_err && !in_stall) begin
            word    = mem[dp_addr[13:2]];
            lane_lo = int'(dp_addr[1:0]);
            for (int b = 0; b < 4; b++) begin
                if (b >= lane_lo && b < lane_lo + (1 << dp_size)) begin
                    word[8*b +: 8] = hwdata[8*b +: 8];
                end
            end
            mem[dp_addr[13:2]] <= word;
        end
    end

endmodule

/* ahb_master.sv */
// AHB-Lite master for a single requester.
// Takes burst commands over a valid/ready handshake and runs them on the AHB bus.
`timescale 1ns/1ps

module ahb_master (
    input  logic                 ahb_clk_in,
    input  logic                 ahb_rstn_in,
    // Requester side.
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  ahb_bus_pkg::haddr_t  cmd_addr,
    input  ahb_bus_pkg::hburst_e cmd_burst,
    input  ahb_bus_pkg::hsize_t  cmd_size,
    input  logic                 cmd_write,
    input  ahb_bus_pkg::hdata_t  wdata,
    output logic                 wdata_ack,
    output ahb_bus_pkg::hdata_t  rdata,
    output logic                 rdata_valid,
    output logic                 xfer_done,
    output logic                 xfer_error,
    // AHB side.
    output ahb_bus_pkg::haddr_t  haddr,
    output ahb_bus_pkg::htrans_e htrans,
    output ahb_bus_pkg::hburst_e hburst,
    output ahb_bus_pkg::hsize_t  hsize,
    output logic                 hwrite,
    output ahb_bus_pkg::hdata_t  hwdata,
    input  ahb_bus_pkg::hdata_t  hrdata,
    input  logic                 hready,
    input  logic                 hresp
);

    logic                cmd_legal;
    logic                load;
    logic                step;
    ahb_bus_pkg::haddr_t beat_addr;
    logic                last_beat;

    ahb_cmd_check u_cmd_check (.*);

    ahb_burst_addr u_burst_addr (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .load        (load),
        .step        (step),
        .load_addr   (cmd_addr),
        .load_burst  (cmd_burst),
        .load_size   (cmd_size),
        .beat_addr   (beat_addr),
        .last_beat   (last_beat)
    );

    ahb_master_ctrl u_ctrl (.*);

endmodule

/* ahb_master_ctrl.sv */
// Transfer controller of the AHB master. Runs the overlapped address and data
// phases of one burst, watches for ERROR and wait timeout, and answers the requester.
`timescale 1ns/1ps
`include "ahb_defs.svh"

module ahb_master_ctrl (
    input  logic                 ahb_clk_in,
    input  logic                 ahb_rstn_in,
    // Command.
    input  logic                 cmd_valid,
    input  logic                 cmd_write,
    input  ahb_bus_pkg::hburst_e cmd_burst,
    input  ahb_bus_pkg::hsize_t  cmd_size,
    input  logic                 cmd_legal,
    output logic                 cmd_ready,
    // Address generator.
    input  ahb_bus_pkg::haddr_t  beat_addr,
    input  logic                 last_beat,
    output logic                 load,
    output logic                 step,
    // Requester data.
    input  ahb_bus_pkg::hdata_t  wdata,
    output logic                 wdata_ack,
    output ahb_bus_pkg::hdata_t  rdata,
    output logic                 rdata_valid,
    output logic                 xfer_done,
    output logic                 xfer_error,
    // AHB.
    output ahb_bus_pkg::haddr_t  haddr,
    output ahb_bus_pkg::htrans_e htrans,
    output ahb_bus_pkg::hburst_e hburst,
    output ahb_bus_pkg::hsize_t  hsize,
    output logic                 hwrite,
    output ahb_bus_pkg::hdata_t  hwdata,
    input  ahb_bus_pkg::hdata_t  hrdata,
    input  logic                 hready,
    input  logic                 hresp
);

    localparam int WAIT_W = $clog2(`AHB_WAIT_TIMEOUT);

    ahb_master_pkg::ctrl_state_e state;
    logic                        addr_active;  // NONSEQ or SEQ on the bus.
    logic                        addr_acc;
    logic                        data_pend;
    logic                        data_wr;
    logic                        last_issued;
    logic                        err_flag;
    logic [WAIT_W-1:0]           wait_cnt;
    logic                        timeout;
    logic                        abort;

    assign addr_active = (htrans == ahb_bus_pkg::NONSEQ) || (htrans == ahb_bus_pkg::SEQ);
    assign addr_acc    = addr_active && hready;

    // Counts low-ready cycles so far, this one is the last allowed.
    assign timeout = (addr_active || data_pend) && !hready
                  && (wait_cnt == WAIT_W'(`AHB_WAIT_TIMEOUT - 1));
    assign abort   = (data_pend && hresp) || timeout;

    assign cmd_ready = (state == ahb_master_pkg::IDLE);
    assign load      = cmd_valid && cmd_ready;
    assign wdata_ack = addr_acc && hwrite;  // Requester moves to the next beat.

    // First beat goes out unconditionally, later ones once the previous is taken.
    assign step = (state == ahb_master_pkg::RUN) && !abort
               && (!addr_active || (hready && !last_issued));

    // ******************************
    // Burst state machine
    // ******************************
    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            state       <= ahb_master_pkg::IDLE;
            htrans      <= ahb_bus_pkg::IDLE;
            haddr       <= '0;
            hburst      <= ahb_bus_pkg::SINGLE;
            hsize       <= '0;
            hwrite      <= 1'b0;
            last_issued <= 1'b0;
            err_flag    <= 1'b0;
            xfer_done   <= 1'b0;
            xfer_error  <= 1'b0;
        end else begin
            xfer_done  <= 1'b0;
            xfer_error <= 1'b0;
            case (state)
                ahb_master_pkg::IDLE: begin
                    if (load) begin
                        hburst      <= cmd_burst;
                        hsize       <= cmd_size;
                        hwrite      <= cmd_write;
                        last_issued <= 1'b0;
                        err_flag    <= !cmd_legal;
                        // An illegal command skips the bus entirely.
                        state <= cmd_legal ? ahb_master_pkg::RUN : ahb_master_pkg::DRAIN;
                    end
                end
                ahb_master_pkg::RUN: begin
                    if (abort) begin
                        htrans   <= ahb_bus_pkg::IDLE;
                        err_flag <= 1'b1;
                        state    <= ahb_master_pkg::DONE;
                    end else if (step) begin
                        haddr       <= beat_addr;
                        htrans      <= addr_active ? ahb_bus_pkg::SEQ : ahb_bus_pkg::NONSEQ;
                        last_issued <= last_beat;
                    end else if (addr_acc) begin  // Last address taken.
                        htrans <= ahb_bus_pkg::IDLE;
                        state  <= ahb_master_pkg::DRAIN;
                    end
                end
                ahb_master_pkg::DRAIN: begin
                    if (abort) begin
                        err_flag <= 1'b1;
                        state    <= ahb_master_pkg::DONE;
                    end else if (!data_pend || hready) begin
                        state <= ahb_master_pkg::DONE;
                    end
                end
                default: begin
                    xfer_done  <= 1'b1;
                    xfer_error <= err_flag;
                    state      <= ahb_master_pkg::IDLE;
                end
            endcase
        end
    end

    // ******************************
    // Data phase tracking
    // ******************************
    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            data_pend   <= 1'b0;
            data_wr     <= 1'b0;
            wait_cnt    <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= data_pend && !data_wr && hready && !hresp;
            if (abort) begin
                data_pend <= 1'b0;
            end else if (hready) begin
                data_pend <= addr_active;  // Accepted address becomes the data phase.
                data_wr   <= hwrite;
            end
            if (hready || abort || !(addr_active || data_pend)) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Write data follows its address into the data phase.
    always_ff @(posedge ahb_clk_in) begin
        if (wdata_ack) begin
            hwdata <= wdata;
        end
        if (data_pend && hready) begin
            rdata <= hrdata;
        end
    end

    // ******************************
    // Assertions
    // ******************************
    a_idle_no_xfer: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        (state == ahb_master_pkg::IDLE) |-> (htrans == ahb_bus_pkg::IDLE));

    // A waited address phase is held until the slave takes it.
    a_haddr_hold: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        (addr_active && !hready) |=> $stable(haddr));

endmodule

/* ahb_burst_addr.sv */
// Beat address generator. Loaded with the command at acceptance, then
// stepped once per issued beat, wrapping inside the burst span for WRAP bursts.
`timescale 1ns/1ps

module ahb_burst_addr (
    input  logic                 ahb_clk_in,
    input  logic                 ahb_rstn_in,
    input  logic                 load,
    input  logic                 step,
    input  ahb_bus_pkg::haddr_t  load_addr,
    input  ahb_bus_pkg::hburst_e load_burst,
    input  ahb_bus_pkg::hsize_t  load_size,
    output ahb_bus_pkg::haddr_t  beat_addr,
    output logic                 last_beat
);

    ahb_master_pkg::beat_cnt_t beat_cnt;
    ahb_bus_pkg::hsize_t       size_q;
    ahb_bus_pkg::haddr_t       span_mask;  // Address bits allowed to change.
    ahb_bus_pkg::haddr_t       load_span;
    ahb_bus_pkg::haddr_t       next_addr;

    // Burst span in bytes.
    assign load_span = ahb_bus_pkg::haddr_t'(ahb_bus_pkg::burst_beats(load_burst)) << load_size;

    // Bits above the span are held, so a wrapping burst folds back to its base.
    assign next_addr = (beat_addr & ~span_mask)
                     | ((beat_addr + (ahb_bus_pkg::haddr_t'(1) << size_q)) & span_mask);

    assign last_beat = (beat_cnt == ahb_master_pkg::beat_cnt_t'(1));

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            beat_addr <= '0;
            beat_cnt  <= '0;
            size_q    <= '0;
            span_mask <= '0;
        end else if (load) begin
            beat_addr <= load_addr;
            beat_cnt  <= ahb_bus_pkg::burst_beats(load_burst);
            size_q    <= load_size;
            span_mask <= ahb_bus_pkg::burst_is_wrap(load_burst) ? (load_span - 1'b1) : '1;
        end else if (step) begin
            beat_addr <= next_addr;
            beat_cnt  <= beat_cnt - 1'b1;
        end
    end

    // ******************************
    // Assertions
    // ******************************
    // The controller never issues more beats than the burst holds.
    a_step_in_burst: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        step |-> (beat_cnt != '0));

endmodule

/* ahb_cmd_check.sv */
// Combinational legality check of a burst command before it reaches the bus.
// An illegal command is completed with an error and never issued.
`timescale 1ns/1ps
`include "ahb_defs.svh"

module ahb_cmd_check (
    input  ahb_bus_pkg::haddr_t  cmd_addr,
    input  ahb_bus_pkg::hburst_e cmd_burst,
    input  ahb_bus_pkg::hsize_t  cmd_size,
    output logic                 cmd_legal
);

    localparam int BOUND_LSB = `AHB_BOUNDARY_BITS;

    ahb_bus_pkg::haddr_t size_bytes;
    ahb_bus_pkg::haddr_t span;
    ahb_bus_pkg::haddr_t first_byte;
    ahb_bus_pkg::haddr_t last_byte;
    logic                burst_ok;
    logic                size_ok;
    logic                aligned;
    logic                in_block;

    assign size_bytes = ahb_bus_pkg::haddr_t'(1) << cmd_size;
    assign span       = ahb_bus_pkg::haddr_t'(ahb_bus_pkg::burst_beats(cmd_burst)) << cmd_size;

    // Wrapping bursts cover the aligned block around the start address.
    assign first_byte = ahb_bus_pkg::burst_is_wrap(cmd_burst) ? (cmd_addr & ~(span - 1'b1))
                                                              : cmd_addr;
    assign last_byte  = first_byte + span - 1'b1;

    assign burst_ok = (cmd_burst != ahb_bus_pkg::INCR);  // Undefined length.
    assign size_ok  = (size_bytes << 3) <= `AHB_DATA_WIDTH;
    assign aligned  = (cmd_addr & (size_bytes - 1'b1)) == '0;
    assign in_block = first_byte[`AHB_ADDR_WIDTH-1:BOUND_LSB] ==
                      last_byte[`AHB_ADDR_WIDTH-1:BOUND_LSB];

    assign cmd_legal = burst_ok && size_ok && aligned && in_block;

endmodule

/* ahb_master_pkg.sv */
// Internal types of the AHB master, shared by the controller and the
// beat address generator.

package ahb_master_pkg;

    // Controller states.
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // Waiting for a command.
        RUN   = 2'd1,  // Issuing address phases.
        DRAIN = 2'd2,  // Last data phase outstanding.
        DONE  = 2'd3   // Reporting completion.
    } ctrl_state_e;

    // Beats still to be issued, up to 16.
    typedef logic [4:0] beat_cnt_t;

endpackage

/* ahb_bus_pkg.sv */
// AHB protocol encodings and bus vector types.
// Used by every RTL block of the master and by the testbench.
`include "ahb_defs.svh"

package ahb_bus_pkg;

    typedef logic [`AHB_ADDR_WIDTH-1:0] haddr_t;
    typedef logic [`AHB_DATA_WIDTH-1:0] hdata_t;
    typedef logic [2:0]                 hsize_t;  // Bytes per beat is 2**hsize.

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUSY   = 2'd1,
        NONSEQ = 2'd2,
        SEQ    = 2'd3
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        INCR   = 3'd1,
        WRAP4  = 3'd2,
        INCR4  = 3'd3,
        WRAP8  = 3'd4,
        INCR8  = 3'd5,
        WRAP16 = 3'd6,
        INCR16 = 3'd7
    } hburst_e;

    // Number of beats in a fixed-length burst.
    function automatic logic [4:0] burst_beats(hburst_e burst);
        case (burst)
            WRAP4, INCR4:   return 5'd4;
            WRAP8, INCR8:   return 5'd8;
            WRAP16, INCR16: return 5'd16;
            default:        return 5'd1;
        endcase
    endfunction

    function automatic logic burst_is_wrap(hburst_e burst);
        return (burst == WRAP4) || (burst == WRAP8) || (burst == WRAP16);
    endfunction

endpackage

/* ahb_defs.svh */
// Bus widths and limits shared by the AHB master RTL and its testbench.
// Include this file wherever one of the macros is needed.

`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

// ******************************
// Bus widths
// ******************************
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// ******************************
// Limits
// ******************************
// Consecutive cycles of ready low before a burst is abandoned.
`define AHB_WAIT_TIMEOUT 6

// A burst may not cross a block of 2**N bytes.
`define AHB_BOUNDARY_BITS 10

`endif
